//--- fsync_pkg.sv
// Barrier node shared definitions
`default_nettype none

package fsync_pkg;

  // Node shape and field widths.
  localparam int unsigned N_CHILDREN     = 2;  // Child ports of one dimension.
  localparam int unsigned AGGR_WIDTH     = 4;  // Aggregate level mask bits.
  localparam int unsigned ID_WIDTH       = 3;  // Barrier id bits, eight table entries.
  localparam int unsigned FIFO_DEPTH_DEF = 2;  // Default depth of every FIFO.

  // Request fields as they travel through the node.
  typedef logic [AGGR_WIDTH-1:0] aggr_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // Decision taken once both children have arrived for an id.
  // Decoded from bit 0 of the aggregate.
  typedef enum logic {
    OP_FORWARD = 1'b0,  // Barrier continues at the parent.
    OP_LOCAL   = 1'b1   // Barrier ends at this node.
  } sync_op_e;

  // Priority state of the child request arbiter.
  typedef enum logic {
    RR_CHILD0 = 1'b0,
    RR_CHILD1 = 1'b1
  } rr_state_e;

endpackage : fsync_pkg

`default_nettype wire

//--- fsync_fifo.sv
// Synchronous FIFO with overflow flag
`timescale 1ns/100ps
`default_nettype none

module fsync_fifo
  import fsync_pkg::*;
#(
  parameter int unsigned DEPTH = FIFO_DEPTH_DEF,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             overflow_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push, do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full;   // A push into a full FIFO is dropped.
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];   // Head entry is always visible.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
      if (push_i && full) overflow_o <= 1'b1;  // Sticky until the next reset.
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule : fsync_fifo

`default_nettype wire

//--- fsync_req_arbiter.sv
// Round-robin child request arbiter
`timescale 1ns/100ps
`default_nettype none

module fsync_req_arbiter
  import fsync_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [N_CHILDREN-1:0] empty_i,
  input  aggr_t                 aggr_i [N_CHILDREN],
  input  id_t                   id_i [N_CHILDREN],
  output logic [N_CHILDREN-1:0] pop_o,
  output logic                  grant_valid_o,
  output logic                  grant_child_o,
  output aggr_t                 grant_aggr_o,
  output id_t                   grant_id_o
);

  rr_state_e rr_q;
  logic      pref;     // Child that currently holds priority.
  logic      granted;
  logic      child;

  always_comb begin
    pref    = (rr_q == RR_CHILD1);
    granted = 1'b0;
    child   = pref;
    if (!empty_i[pref]) begin
      granted = 1'b1;
    end else if (!empty_i[!pref]) begin
      granted = 1'b1;
      child   = !pref;   // Fall back to the other child.
    end
    pop_o        = '0;
    pop_o[child] = granted;
  end

  assign grant_valid_o = granted;
  assign grant_child_o = child;
  assign grant_aggr_o  = aggr_i[child];
  assign grant_id_o    = id_i[child];

  // Priority passes to the child that lost, or waited, in this cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= RR_CHILD0;
    end else if (granted) begin
      rr_q <= child ? RR_CHILD0 : RR_CHILD1;
    end
  end

endmodule : fsync_req_arbiter

`default_nettype wire

//--- fsync_control.sv
// Barrier arrival control core
`timescale 1ns/100ps
`default_nettype none

module fsync_control
  import fsync_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  grant_valid_i,
  input  logic  grant_child_i,
  input  aggr_t grant_aggr_i,
  input  id_t   grant_id_i,
  output logic  local_valid_o,
  output id_t   local_id_o,
  output logic  up_req_valid_o,
  output aggr_t up_req_aggr_o,
  output id_t   up_req_id_o
);

  localparam int unsigned N_IDS = 2**ID_WIDTH;

  // One arrival bit per child for every barrier id.
  logic [N_CHILDREN-1:0] arrived_q [N_IDS];

  sync_op_e op;
  logic     partner_here;
  logic     complete;

  always_comb begin
    op           = grant_aggr_i[0] ? OP_LOCAL : OP_FORWARD;
    partner_here = arrived_q[grant_id_i][!grant_child_i];
    complete     = grant_valid_i && partner_here;  // Second arrival closes the barrier.
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_IDS; i++) begin
        arrived_q[i] <= '0;
      end
    end else if (grant_valid_i) begin
      if (complete) begin
        arrived_q[grant_id_i] <= '0;  // Entry is free for the next round of this id.
      end else begin
        // A repeat from the same child rewrites a bit that is already set.
        arrived_q[grant_id_i][grant_child_i] <= 1'b1;
      end
    end
  end

  // One-cycle pulses, registered after the completing grant.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_valid_o  <= 1'b0;
      up_req_valid_o <= 1'b0;
    end else begin
      local_valid_o  <= complete && (op == OP_LOCAL);
      up_req_valid_o <= complete && (op == OP_FORWARD);
    end
  end

  always_ff @(posedge clk_i) begin
    if (complete) begin
      local_id_o    <= grant_id_i;
      up_req_id_o   <= grant_id_i;
      up_req_aggr_o <= grant_aggr_i >> 1;  // Next level sees its own bit at position 0.
    end
  end

endmodule : fsync_control

`default_nettype wire

//--- fsync_rsp_arbiter.sv
// Child response arbiter
`timescale 1ns/100ps
`default_nettype none

module fsync_rsp_arbiter
  import fsync_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  local_valid_i,
  input  id_t                   local_id_i,
  input  logic                  down_empty_i,
  input  id_t                   down_id_i,
  output logic                  down_pop_o,
  output logic [N_CHILDREN-1:0] rsp_valid_o,
  output id_t                   rsp_id_o
);

  logic rsp_valid_q;

  // The down FIFO holds its entry while a local response owns the port.
  assign down_pop_o = !local_valid_i && !down_empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= local_valid_i || down_pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (local_valid_i) begin
      rsp_id_o <= local_id_i;
    end else if (down_pop_o) begin
      rsp_id_o <= down_id_i;
    end
  end

  assign rsp_valid_o = {N_CHILDREN{rsp_valid_q}};  // Broadcast to every child.

endmodule : fsync_rsp_arbiter

`default_nettype wire

//--- fsync_node.sv
// Barrier synchronization node
`timescale 1ns/100ps
`default_nettype none

module fsync_node
  import fsync_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [N_CHILDREN-1:0] req_valid_i,
  input  aggr_t                 req_aggr_i [N_CHILDREN],
  input  id_t                   req_id_i [N_CHILDREN],
  output logic [N_CHILDREN-1:0] rsp_valid_o,
  output id_t                   rsp_id_o,
  output logic                  up_req_valid_o,
  output aggr_t                 up_req_aggr_o,
  output id_t                   up_req_id_o,
  input  logic                  up_rsp_valid_i,
  input  id_t                   up_rsp_id_i,
  output logic                  overflow_o
);

  localparam int unsigned REQ_W = AGGR_WIDTH + ID_WIDTH;

  logic [REQ_W-1:0]      child_head [N_CHILDREN];
  logic [N_CHILDREN-1:0] child_empty;
  logic [N_CHILDREN-1:0] child_pop;
  logic [N_CHILDREN-1:0] child_ovf;
  aggr_t                 head_aggr [N_CHILDREN];
  id_t                   head_id [N_CHILDREN];

  logic  grant_valid, grant_child;
  aggr_t grant_aggr;
  id_t   grant_id;
  logic  local_valid;
  id_t   local_id;
  logic  down_empty, down_pop, down_ovf;
  id_t   down_id;

  for (genvar c = 0; c < N_CHILDREN; c++) begin : gen_child
    fsync_fifo #(
      .DEPTH (FIFO_DEPTH),
      .WIDTH (REQ_W)
    ) u_child_fifo (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_i     (req_valid_i[c]),
      .data_i     ({req_aggr_i[c], req_id_i[c]}),
      .pop_i      (child_pop[c]),
      .data_o     (child_head[c]),
      .empty_o    (child_empty[c]),
      .overflow_o (child_ovf[c])
    );
    assign head_aggr[c] = child_head[c][REQ_W-1:ID_WIDTH];
    assign head_id[c]   = child_head[c][ID_WIDTH-1:0];
  end

  fsync_req_arbiter u_req_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .empty_i       (child_empty),
    .aggr_i        (head_aggr),
    .id_i          (head_id),
    .pop_o         (child_pop),
    .grant_valid_o (grant_valid),
    .grant_child_o (grant_child),
    .grant_aggr_o  (grant_aggr),
    .grant_id_o    (grant_id)
  );

  fsync_control u_control (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .grant_valid_i  (grant_valid),
    .grant_child_i  (grant_child),
    .grant_aggr_i   (grant_aggr),
    .grant_id_i     (grant_id),
    .local_valid_o  (local_valid),
    .local_id_o     (local_id),
    .up_req_valid_o (up_req_valid_o),
    .up_req_aggr_o  (up_req_aggr_o),
    .up_req_id_o    (up_req_id_o)
  );

  // Parent responses wait here until the child port is free.
  fsync_fifo #(
    .DEPTH (FIFO_DEPTH),
    .WIDTH (ID_WIDTH)
  ) u_down_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (up_rsp_valid_i),
    .data_i     (up_rsp_id_i),
    .pop_i      (down_pop),
    .data_o     (down_id),
    .empty_o    (down_empty),
    .overflow_o (down_ovf)
  );

  fsync_rsp_arbiter u_rsp_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .local_valid_i (local_valid),
    .local_id_i    (local_id),
    .down_empty_i  (down_empty),
    .down_id_i     (down_id),
    .down_pop_o    (down_pop),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_id_o      (rsp_id_o)
  );

  assign overflow_o = |child_ovf || down_ovf;  // Any dropped write in the node.

endmodule : fsync_node

`default_nettype wire

//--- tb_fsync_node.sv
// Barrier node testbench
`timescale 1ns/100ps
`default_nettype none

module tb_fsync_node
  import fsync_pkg::*;
();

  localparam int CHECK_WAIT = 30;  // Cycles a check waits for late events.

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic [N_CHILDREN-1:0] req_valid_i;
  aggr_t                 req_aggr_i [N_CHILDREN];
  id_t                   req_id_i [N_CHILDREN];
  logic [N_CHILDREN-1:0] rsp_valid_o;
  id_t                   rsp_id_o;
  logic                  up_req_valid_o;
  aggr_t                 up_req_aggr_o;
  id_t                   up_req_id_o;
  logic                  up_rsp_valid_i;
  id_t                   up_rsp_id_i;
  logic                  overflow_o;

  // Events pack kind, aggr and id. Kind 1 is a child response, kind 2 an upward request.
  logic [23:0]           obs_q[$];
  logic [23:0]           exp_q[$];
  logic [23:0]           mdl_q[$];
  logic [N_CHILDREN-1:0] mdl_arr [2**ID_WIDTH];  // Scoreboard copy of the arrival table.
  logic [31:0]           seed = 32'h6374;
  int                    budget = 50;  // Grows with every pattern line read.
  int                    cycles = 0;
  int                    test_errs = 0;
  int                    total_errs = 0;
  int                    n_tests = 0;
  int                    n_failed = 0;

  fsync_node #(
    .FIFO_DEPTH (FIFO_DEPTH_DEF)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_aggr_i     (req_aggr_i),
    .req_id_i       (req_id_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_id_o       (rsp_id_o),
    .up_req_valid_o (up_req_valid_o),
    .up_req_aggr_o  (up_req_aggr_o),
    .up_req_id_o    (up_req_id_o),
    .up_rsp_valid_i (up_rsp_valid_i),
    .up_rsp_id_i    (up_rsp_id_i),
    .overflow_o     (overflow_o)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period.

  // Outputs are sampled mid-cycle, away from the driving edge.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rsp_valid_o != '0) begin
        if (rsp_valid_o != {N_CHILDREN{1'b1}}) begin
          $display("** Error rsp_valid_o: got %h, expected %h", rsp_valid_o,
                   {N_CHILDREN{1'b1}});
          test_errs++;
        end
        obs_q.push_back({8'd1, 8'd0, 8'(rsp_id_o)});
      end
      if (up_req_valid_o) begin
        obs_q.push_back({8'd2, 8'(up_req_aggr_o), 8'(up_req_id_o)});
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > budget) begin
      $display("Timeout after %0d cycles, the pattern run did not finish", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Moves to the next rising edge and drops the one-cycle request pulses.
  task automatic cycle_start();
    @(posedge clk_i);
    req_valid_i    <= '0;
    up_rsp_valid_i <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni         <= 1'b0;
    req_valid_i    <= '0;
    up_rsp_valid_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    obs_q.delete();
    exp_q.delete();
    mdl_q.delete();
    foreach (mdl_arr[k]) mdl_arr[k] = '0;
  endtask

  task automatic report_bad_line(input string op);
    $display("Pattern line %s has missing or malformed fields", op);
    test_errs++;
  endtask

  // The second child to arrive closes the barrier. Bit 0 of its aggregate picks the result.
  task automatic model_request(input int c, input aggr_t a, input id_t id);
    if (mdl_arr[id][1-c]) begin
      mdl_arr[id] = '0;
      if (a[0]) mdl_q.push_back({8'd1, 8'd0, 8'(id)});
      else mdl_q.push_back({8'd2, 8'(a >> 1), 8'(id)});
    end else begin
      mdl_arr[id][c] = 1'b1;  // A repeat from the same child changes nothing.
    end
  endtask

  task automatic check_test(input string name);
    int   waited;
    logic found;
    waited = 0;
    while (obs_q.size() < exp_q.size() && waited < CHECK_WAIT) begin
      cycle_start();
      waited++;
    end
    repeat (4) cycle_start();  // Extra events would show up here.
    if (obs_q.size() != exp_q.size()) begin
      $display("%s: %0d events seen where %0d were expected", name, obs_q.size(),
               exp_q.size());
      test_errs++;
    end
    for (int k = 0; k < obs_q.size() && k < exp_q.size(); k++) begin
      if (obs_q[k][23:16] != exp_q[k][23:16]) begin
        $display("%s: event %0d is of the wrong kind", name, k);
        test_errs++;
      end else if (obs_q[k][23:16] == 8'd1 && obs_q[k][7:0] != exp_q[k][7:0]) begin
        $display("** Error rsp_id_o: got %h, expected %h", obs_q[k][7:0], exp_q[k][7:0]);
        test_errs++;
      end else if (obs_q[k] != exp_q[k]) begin
        $display("** Error up_req_aggr_o/up_req_id_o: got %h/%h, expected %h/%h",
                 obs_q[k][15:8], obs_q[k][7:0], exp_q[k][15:8], exp_q[k][7:0]);
        test_errs++;
      end
    end
    foreach (obs_q[k]) begin
      found = 1'b0;
      for (int m = 0; m < mdl_q.size() && !found; m++) begin
        if (mdl_q[m] == obs_q[k]) begin
          mdl_q.delete(m);
          found = 1'b1;
        end
      end
      if (!found) begin
        $display("%s: event %h was not predicted by the scoreboard", name, obs_q[k]);
        test_errs++;
      end
    end
    if (mdl_q.size() != 0) begin
      $display("%s: %0d predicted events never arrived", name, mdl_q.size());
      test_errs++;
    end
    n_tests++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("%s: ok", name);
    end else begin
      n_failed++;
      $display("%s: %0d errors", name, test_errs);
    end
    test_errs = 0;
    obs_q.delete();
    exp_q.delete();
    mdl_q.delete();
  endtask

  initial begin
    int          fd;
    int          c;
    int          n;
    int          ch;
    logic [31:0] v_aggr;
    logic [31:0] v_id;
    string       op;
    string       tname;
    rst_ni         = 1'b0;
    req_valid_i    = '0;
    up_rsp_valid_i = 1'b0;
    up_rsp_id_i    = '0;
    foreach (req_aggr_i[k]) begin
      req_aggr_i[k] = '0;
      req_id_i[k]   = '0;
    end
    apply_reset();
    fd = $fopen("fsync_patterns.txt", "r");
    if (fd == 0) begin
      $display("Pattern file fsync_patterns.txt could not be opened");
      total_errs++;
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        budget += 50;
        if (op == "#") begin
          do begin
            ch = $fgetc(fd);
          end while (ch != 10 && ch != -1);
        end else if (op == "req") begin
          if ($fscanf(fd, "%d %h %h", c, v_aggr, v_id) != 3) report_bad_line(op);
          cycle_start();
          req_valid_i[c] <= 1'b1;
          req_aggr_i[c]  <= aggr_t'(v_aggr);
          req_id_i[c]    <= id_t'(v_id);
          model_request(c, aggr_t'(v_aggr), id_t'(v_id));
        end else if (op == "rsp") begin
          if ($fscanf(fd, "%h", v_id) != 1) report_bad_line(op);
          cycle_start();
          up_rsp_valid_i <= 1'b1;
          up_rsp_id_i    <= id_t'(v_id);
          mdl_q.push_back({8'd1, 8'd0, 8'(id_t'(v_id))});
        end else if (op == "flood") begin
          if ($fscanf(fd, "%d", n) != 1) report_bad_line(op);
          budget += n;
          repeat (n) begin
            cycle_start();
            for (int k = 0; k < N_CHILDREN; k++) begin
              seed = lcg_next(seed);
              req_valid_i[k] <= 1'b1;
              req_aggr_i[k]  <= seed[19:16];
              req_id_i[k]    <= seed[26:24];
            end
          end
        end else if (op == "wait") begin
          if ($fscanf(fd, "%d", n) != 1) report_bad_line(op);
          repeat (n) cycle_start();
        end else if (op == "exp_rsp") begin
          if ($fscanf(fd, "%h", v_id) != 1) report_bad_line(op);
          exp_q.push_back({8'd1, 8'd0, v_id[7:0]});
        end else if (op == "exp_up") begin
          if ($fscanf(fd, "%h %h", v_aggr, v_id) != 2) report_bad_line(op);
          exp_q.push_back({8'd2, v_aggr[7:0], v_id[7:0]});
        end else if (op == "ovf") begin
          if ($fscanf(fd, "%d", n) != 1) report_bad_line(op);
          @(negedge clk_i);
          if (overflow_o !== n[0]) begin
            $display("** Error overflow_o: got %h, expected %h", overflow_o, n[0]);
            test_errs++;
          end
        end else if (op == "reset") begin
          apply_reset();
        end else if (op == "check") begin
          if ($fscanf(fd, "%s", tname) != 1) report_bad_line(op);
          check_test(tname);
        end else begin
          $display("Unknown opcode %s in the pattern file", op);
          test_errs++;
        end
      end
      $fclose(fd);
    end
    total_errs += test_errs;
    $display("tests run: %0d, tests failed: %0d, errors: %0d", n_tests, n_failed, total_errs);
    if (total_errs == 0 && n_failed == 0 && n_tests > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_fsync_node

`default_nettype wire

//--- fsync_patterns.txt
# Columns: opcode and fields. req child aggr id, rsp id, flood cycles, wait cycles,
# exp_rsp id, exp_up aggr id, ovf level, reset, check name. Aggr and id are hex.
# Both children reach id 5 and the barrier ends here.
req 0 1 5
req 1 1 5
exp_rsp 5
check local_barrier
req 0 6 2
req 1 6 2
exp_up 3 2
check forwarded_barrier
rsp 4
rsp 1
exp_rsp 4
exp_rsp 1
check parent_response
# Ids 3, 1 and 6 interleave, child 1 repeats id 1 before child 0 arrives.
req 0 3 3
req 1 1 1
req 0 2 6
req 1 1 1
req 1 3 3
req 0 1 1
req 1 2 6
exp_rsp 3
exp_rsp 1
exp_up 1 6
check ids_in_flight
# The parent response lands in the down FIFO while the local response owns the port.
req 0 1 7
req 1 1 7
rsp 0
exp_rsp 7
exp_rsp 0
check collision
flood 8
wait 10
ovf 1
wait 4
ovf 1
reset
ovf 0
check overflow

//--- sim.f
fsync_pkg.sv
fsync_fifo.sv
fsync_req_arbiter.sv
fsync_control.sv
fsync_rsp_arbiter.sv
fsync_node.sv
tb_fsync_node.sv
